//--- xc_cfg_pkg.sv
package xc_cfg_pkg;

    // Detector front end
    localparam int NUM_LINES = 4;                     // Detector lines
    localparam int NUM_LAGS  = 4;                     // Autocorrelation lags 0 to 3
    localparam int NUM_PAIRS = NUM_LINES * (NUM_LINES - 1) / 2; // Six line pairs

    localparam int LINE_W = $clog2(NUM_LINES);        // Bits to select a line
    localparam int LAG_W  = $clog2(NUM_LAGS);         // Bits to select a lag
    localparam int PAIR_W = $clog2(NUM_PAIRS);        // Bits to select a pair

    // Counter sizing
    localparam int COUNT_W = 16;                      // Coincidence counter width
    localparam logic [COUNT_W-1:0] COUNT_MAX = {COUNT_W{1'b1}}; // Saturation value

    // Pair table, pair p correlates line PAIR_A[p] with line PAIR_B[p]
    localparam int PAIR_A [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2}; // First line of pair
    localparam int PAIR_B [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3}; // Second line of pair

    // Frame layout
    localparam int INDEX_W      = 6;                           // Word index width
    localparam int HEADER_WORDS = 1;                           // Sequence header
    localparam int AUTO_WORDS   = NUM_LINES * NUM_LAGS;        // One per line and lag
    localparam int CROSS_WORDS  = NUM_PAIRS;                   // One per pair
    localparam int AUTO_BASE    = HEADER_WORDS;                // First auto word slot
    localparam int CROSS_BASE   = AUTO_BASE + AUTO_WORDS;      // First cross word slot
    localparam int FRAME_WORDS  = CROSS_BASE + CROSS_WORDS;    // 23 words per frame

endpackage

//--- xc_types_pkg.sv
package xc_types_pkg;

    import xc_cfg_pkg::*;

    // Basic vectors
    typedef logic [NUM_LINES-1:0] line_vec_t;        // One bit per detector line
    typedef logic [COUNT_W-1:0]   count_t;           // One saturating count

    // Tag carried by every report word
    typedef enum logic [1:0] {
        KIND_HEADER = 2'd0,                          // Sequence number word
        KIND_AUTO   = 2'd1,                          // Autocorrelation word
        KIND_CROSS  = 2'd2                           // Crosscorrelation word
    } word_kind_t;

    // Edge history from the sampler, past[k] holds the edges of k cycles ago
    typedef struct packed {
        line_vec_t [NUM_LAGS-1:1] past;              // Lags 3 down to 1
        line_vec_t                now;               // Edges of this cycle
    } edge_hist_t;

    // Autocorrelation bank, count[line][lag]
    typedef struct packed {
        count_t [NUM_LINES-1:0][NUM_LAGS-1:0] count; // 16 counts, 256 bits
    } auto_counts_t;

    // Crosscorrelation bank in pair order
    typedef struct packed {
        count_t [NUM_PAIRS-1:0] count;               // 6 counts, 96 bits
    } cross_counts_t;

    // One tagged output word
    typedef struct packed {
        word_kind_t         kind;                    // Header, auto or cross
        logic [INDEX_W-1:0] index;                   // Line*4+lag or pair number
        count_t             count;                   // Count or sequence number
    } report_word_t;

endpackage

//--- line_sampler.sv
`timescale 1ns/1ps

module line_sampler (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [xc_cfg_pkg::NUM_LINES-1:0]  line_in,   // Raw detector levels
    output xc_types_pkg::edge_hist_t          hist       // Edges with lagged copies
);

    import xc_cfg_pkg::*;
    import xc_types_pkg::*;

    line_vec_t                sync1_q;                   // First synchronizer stage
    line_vec_t                sync2_q;                   // Second synchronizer stage
    line_vec_t                prev_q;                    // Level one cycle earlier
    line_vec_t                edge_q;                    // Registered rising edges
    line_vec_t [NUM_LAGS-1:1] past_q;                    // Edge history, lag 1 in slot 1

    // Synchronizer, edge detect and history shift share one register stage each
    always_ff @(posedge clk) begin
        if (reset) begin
            sync1_q <= '0;                               // Lines read as idle low
            sync2_q <= '0;
            prev_q  <= '0;
            edge_q  <= '0;                               // No spurious edge out of reset
            past_q  <= '0;                               // History starts empty
        end else begin
            sync1_q <= line_in;                          // Capture asynchronous levels
            sync2_q <= sync1_q;                          // Settle metastability
            prev_q  <= sync2_q;                          // Remember last clean level
            edge_q  <= sync2_q & ~prev_q;                // Rising edge, 0 then 1
            past_q  <= {past_q[NUM_LAGS-2:1], edge_q};   // Shift older edges upward
        end
    end

    // Edges reach the correlators three cycles after line_in changes
    assign hist.now  = edge_q;                           // Current edge vector
    assign hist.past = past_q;                           // Lags 1 to 3

endmodule

//--- auto_correlator.sv
`timescale 1ns/1ps

module auto_correlator (
    input  logic                         clk,
    input  logic                         reset,
    input  xc_types_pkg::edge_hist_t     hist,      // Edge history from sampler
    input  logic                         snap,      // Snapshot and restart strobe
    output xc_types_pkg::auto_counts_t   counts     // Snapshot bank
);

    import xc_cfg_pkg::*;
    import xc_types_pkg::*;

    logic [NUM_LINES-1:0][NUM_LAGS-1:0] hit;        // Coincidence this cycle
    auto_counts_t                       live_q;     // Counters of the open window
    auto_counts_t                       snap_q;     // Counters of the last window

    // A lag k hit needs an edge now and an edge k cycles back on the same line
    always_comb begin
        for (int i = 0; i < NUM_LINES; i++) begin
            hit[i][0] = hist.now[i];                // Lag 0 is the plain edge count
            for (int k = 1; k < NUM_LAGS; k++) begin
                hit[i][k] = hist.now[i] & hist.past[k][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            live_q <= '0;                           // Empty window
            snap_q <= '0;                           // Nothing captured yet
        end else begin
            if (snap) begin
                snap_q <= live_q;                   // Freeze the closing window
            end
            for (int i = 0; i < NUM_LINES; i++) begin
                for (int k = 0; k < NUM_LAGS; k++) begin
                    if (snap) begin
                        // Restart, a hit in the snap cycle opens the new window
                        live_q.count[i][k] <= COUNT_W'(hit[i][k]);
                    end else if (hit[i][k] && live_q.count[i][k] != COUNT_MAX) begin
                        live_q.count[i][k] <= live_q.count[i][k] + 1'b1; // Saturating
                    end
                end
            end
        end
    end

    assign counts = snap_q;                         // Framer reads the frozen bank

    // Counters only move upward between snapshots
    for (genvar gi = 0; gi < NUM_LINES; gi++) begin : g_line_chk
        for (genvar gk = 0; gk < NUM_LAGS; gk++) begin : g_lag_chk
            a_live_monotonic: assert property (
                @(posedge clk) disable iff (reset)
                !snap |=> live_q.count[gi][gk] >= $past(live_q.count[gi][gk])
            );
        end
    end

endmodule

//--- cross_correlator.sv
`timescale 1ns/1ps

module cross_correlator (
    input  logic                          clk,
    input  logic                          reset,
    input  xc_types_pkg::edge_hist_t      hist,     // Edge history from sampler
    input  logic                          snap,     // Snapshot and restart strobe
    output xc_types_pkg::cross_counts_t   counts    // Snapshot bank
);

    import xc_cfg_pkg::*;
    import xc_types_pkg::*;

    logic [NUM_PAIRS-1:0] hit;                      // Same-cycle pair coincidence
    cross_counts_t        live_q;                   // Counters of the open window
    cross_counts_t        snap_q;                   // Counters of the last window

    // Both lines of the pair must show an edge in the same cycle
    always_comb begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
            hit[p] = hist.now[PAIR_A[p]] & hist.now[PAIR_B[p]];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            live_q <= '0;                           // Empty window
            snap_q <= '0;                           // Nothing captured yet
        end else begin
            if (snap) begin
                snap_q <= live_q;                   // Freeze the closing window
            end
            for (int p = 0; p < NUM_PAIRS; p++) begin
                if (snap) begin
                    live_q.count[p] <= COUNT_W'(hit[p]); // Restart with this cycle's hit
                end else if (hit[p] && live_q.count[p] != COUNT_MAX) begin
                    live_q.count[p] <= live_q.count[p] + 1'b1; // Hold at 65535
                end
            end
        end
    end

    assign counts = snap_q;                         // Framer reads the frozen bank

    // The framer issues one snap per accepted capture, never back to back
    a_snap_single: assert property (
        @(posedge clk) disable iff (reset)
        snap |=> !snap
    );

endmodule

//--- report_framer.sv
`timescale 1ns/1ps

module report_framer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          capture,      // One-cycle capture request
    input  xc_types_pkg::auto_counts_t    auto_counts,  // Frozen auto bank
    input  xc_types_pkg::cross_counts_t   cross_counts, // Frozen cross bank
    output logic                          snap,         // Snapshot strobe to correlators
    output xc_types_pkg::report_word_t    word,         // Tagged frame word
    output logic                          word_valid,   // Word strobe
    output logic                          busy          // Frame in progress
);

    import xc_cfg_pkg::*;
    import xc_types_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,                                        // Waiting for capture
        ST_SNAP,                                        // Snap strobe on the wire
        ST_SEND                                         // Streaming frame words
    } state_t;

    state_t             state_q;                        // Sequencer state
    logic               snap_q;                         // Registered snap strobe
    logic               valid_q;                        // Registered word strobe
    logic               busy_q;                         // Registered busy level
    logic [INDEX_W-1:0] idx_q;                          // Slot of the next word
    count_t             seq_q;                          // Frame sequence number
    report_word_t       word_q;                         // Output word register
    report_word_t       next_word;                      // Word for slot idx_q
    logic [INDEX_W-1:0] auto_off;                       // Slot relative to auto base
    logic [INDEX_W-1:0] cross_off;                      // Slot relative to cross base
    logic               last_slot;                      // Final word of the frame

    assign last_slot = (idx_q == INDEX_W'(FRAME_WORDS - 1));

    // Frame layout decode, header then auto words then cross words
    always_comb begin
        auto_off  = idx_q - INDEX_W'(AUTO_BASE);
        cross_off = idx_q - INDEX_W'(CROSS_BASE);
        if (idx_q < INDEX_W'(AUTO_BASE)) begin
            next_word.kind  = KIND_HEADER;
            next_word.index = '0;                       // Header index is fixed
            next_word.count = seq_q;                    // Carries the sequence number
        end else if (idx_q < INDEX_W'(CROSS_BASE)) begin
            next_word.kind  = KIND_AUTO;
            next_word.index = auto_off;                 // Line*4 + lag by construction
            next_word.count = auto_counts.count[auto_off[LAG_W +: LINE_W]]
                                               [auto_off[LAG_W-1:0]];
        end else begin
            next_word.kind  = KIND_CROSS;
            next_word.index = cross_off;                // Pair number
            next_word.count = cross_counts.count[cross_off[PAIR_W-1:0]];
        end
    end

    // Capture control and word sequencer
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
            snap_q  <= 1'b0;
            valid_q <= 1'b0;
            busy_q  <= 1'b0;
            idx_q   <= '0;
            seq_q   <= '0;                              // First frame reports 0
        end else begin
            case (state_q)
                ST_IDLE: begin
                    valid_q <= 1'b0;                    // Drops after the last word
                    busy_q  <= 1'b0;
                    if (capture && !busy_q) begin       // Last-word cycle still busy
                        busy_q  <= 1'b1;
                        snap_q  <= 1'b1;                // Snap in the next cycle
                        state_q <= ST_SNAP;
                    end
                end
                ST_SNAP: begin
                    snap_q  <= 1'b0;                    // Single-cycle strobe
                    idx_q   <= '0;                      // Start at the header
                    state_q <= ST_SEND;
                end
                ST_SEND: begin
                    valid_q <= 1'b1;                    // One word per cycle
                    idx_q   <= idx_q + 1'b1;
                    if (last_slot) begin
                        seq_q   <= seq_q + 1'b1;        // Next frame number
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Payload register, qualified by word_valid
    always_ff @(posedge clk) begin
        if (state_q == ST_SEND) begin
            word_q <= next_word;
        end
    end

    assign snap       = snap_q;
    assign word       = word_q;
    assign word_valid = valid_q;
    assign busy       = busy_q;

    a_valid_in_busy: assert property (
        @(posedge clk) disable iff (reset)
        word_valid |-> busy
    );

endmodule

//--- xc_core.sv
`timescale 1ns/1ps

module xc_core (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [xc_cfg_pkg::NUM_LINES-1:0]  line_in,     // Detector levels
    input  logic                              capture,     // Capture strobe
    output xc_types_pkg::report_word_t        word,        // Tagged frame word
    output logic                              word_valid,  // Word strobe
    output logic                              busy         // Frame in progress
);

    import xc_types_pkg::*;

    edge_hist_t    hist;                       // Shared edge stream
    logic          snap;                       // Snapshot strobe
    auto_counts_t  auto_counts;                // Frozen auto bank
    cross_counts_t cross_counts;               // Frozen cross bank

    // Front end, sync and edge history
    line_sampler sampler_i (
        .clk     (clk),
        .reset   (reset),
        .line_in (line_in),
        .hist    (hist)
    );

    // Same-line lagged coincidences
    auto_correlator auto_i (
        .clk    (clk),
        .reset  (reset),
        .hist   (hist),
        .snap   (snap),
        .counts (auto_counts)
    );

    // Pairwise same-cycle coincidences
    cross_correlator cross_i (
        .clk    (clk),
        .reset  (reset),
        .hist   (hist),
        .snap   (snap),
        .counts (cross_counts)
    );

    // Capture handling and frame output
    report_framer framer_i (
        .clk          (clk),
        .reset        (reset),
        .capture      (capture),
        .auto_counts  (auto_counts),
        .cross_counts (cross_counts),
        .snap         (snap),
        .word         (word),
        .word_valid   (word_valid),
        .busy         (busy)
    );

endmodule

//--- tb_xc_core.sv
`timescale 1ns/1ps

module tb_xc_core;

    import xc_cfg_pkg::*;
    import xc_types_pkg::*;

    localparam int WAIT_LIMIT  = 50;                  // Cycles allowed for a frame to start
    localparam int QUIET_LIMIT = 40;                  // Cycles watched for a stray frame

    logic         clk;
    logic         reset;
    line_vec_t    line_in;
    logic         capture;
    report_word_t word;
    logic         word_valid;
    logic         busy;

    int           value_errors;                       // Wrong values seen
    int           other_errors;                       // Timeouts and framing faults
    integer       seed;                               // Random stream state
    int           exp_seq;                            // Next expected header number
    line_vec_t    model_level;                        // Last driven levels
    line_vec_t    model_hist [1:NUM_LAGS-1];          // Edges of 1 to 3 cycles ago
    int           model_auto [NUM_LINES][NUM_LAGS];   // Reference auto counts
    int           model_cross [NUM_PAIRS];            // Reference cross counts
    report_word_t exp_words [FRAME_WORDS];            // Expected frame

    xc_core dut_i (
        .clk        (clk),
        .reset      (reset),
        .line_in    (line_in),
        .capture    (capture),
        .word       (word),
        .word_valid (word_valid),
        .busy       (busy)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;                             // 100 MHz

    function automatic count_t sat_count(input int n);
        if (n > 65535) begin
            return count_t'(65535);                   // Counter holds at full scale
        end
        return count_t'(n);
    endfunction

    task automatic finish_run();
        $display("Closing: %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic check_word(input report_word_t got, input report_word_t exp,
                              input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0d ns: %s got kind %0d index %0d count %0d", $time, what,
                     got.kind, got.index, got.count);
            $display("    expected kind %0d index %0d count %0d", exp.kind, exp.index,
                     exp.count);
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0d ns: %s busy is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic clear_counts();
        for (int i = 0; i < NUM_LINES; i++) begin
            for (int k = 0; k < NUM_LAGS; k++) begin
                model_auto[i][k] = 0;
            end
        end
        for (int p = 0; p < NUM_PAIRS; p++) begin
            model_cross[p] = 0;
        end
    endtask

    task automatic apply_reset();
        reset   = 1'b1;
        line_in = '0;
        capture = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset       = 1'b0;
        model_level = '0;                             // Sampler restarts from idle low
        for (int k = 1; k < NUM_LAGS; k++) begin
            model_hist[k] = '0;
        end
        clear_counts();
        exp_seq = 0;
    endtask

    // Drives one clock of stimulus and feeds its edges to the model
    task automatic drive_lines(input line_vec_t v);
        line_vec_t edges;
        int        p;
        @(posedge clk);
        #1;
        line_in     = v;
        edges       = v & ~model_level;               // Rising edges only
        model_level = v;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (edges[i]) begin
                model_auto[i][0]++;                   // Lag 0 is every edge
                for (int k = 1; k < NUM_LAGS; k++) begin
                    if (model_hist[k][i]) begin
                        model_auto[i][k]++;
                    end
                end
            end
        end
        p = 0;
        for (int a = 0; a < NUM_LINES; a++) begin
            for (int b = a + 1; b < NUM_LINES; b++) begin
                if (edges[a] && edges[b]) begin
                    model_cross[p]++;                 // Pairs (0,1) (0,2) ... (2,3)
                end
                p++;
            end
        end
        for (int k = NUM_LAGS - 1; k > 1; k--) begin
            model_hist[k] = model_hist[k-1];
        end
        model_hist[1] = edges;
    endtask

    task automatic pulse_line(input line_vec_t v, input int period);
        drive_lines(v);                               // High for one cycle
        repeat (period - 1) drive_lines('0);
    endtask

    // Quiet lines, freeze the model into the expected frame, then strobe capture
    task automatic do_capture();
        report_word_t w;
        repeat (8) drive_lines('0);                   // Late edges land in this window
        w.kind  = KIND_HEADER;
        w.index = '0;
        w.count = count_t'(exp_seq);
        exp_words[0] = w;
        for (int i = 0; i < NUM_LINES; i++) begin
            for (int k = 0; k < NUM_LAGS; k++) begin
                w.kind  = KIND_AUTO;
                w.index = INDEX_W'(i * 4 + k);        // Line times 4 plus lag
                w.count = sat_count(model_auto[i][k]);
                exp_words[1 + i * 4 + k] = w;
            end
        end
        for (int p = 0; p < NUM_PAIRS; p++) begin
            w.kind  = KIND_CROSS;
            w.index = INDEX_W'(p);
            w.count = sat_count(model_cross[p]);
            exp_words[17 + p] = w;                    // After header and 16 auto words
        end
        exp_seq++;
        clear_counts();                               // New window opens
        @(posedge clk);
        #1;
        capture = 1'b1;
        @(posedge clk);
        #1;
        capture = 1'b0;
        check_busy(busy, 1'b1, "after accepted capture");
    endtask

    task automatic collect_frame(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!word_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!word_valid) begin
            $display("Timed out waiting for word_valid in %s", what);
            other_errors++;
        end else begin
            for (int n = 0; n < FRAME_WORDS; n++) begin
                if (n > 0) begin
                    @(negedge clk);                   // Words are stable mid-cycle
                end
                if (!word_valid) begin
                    $display("word_valid dropped early at word %0d in %s", n, what);
                    other_errors++;
                end
                check_busy(busy, 1'b1, $sformatf("%s word %0d", what, n));
                check_word(word, exp_words[n], $sformatf("%s word %0d", what, n));
            end
            @(negedge clk);
            if (word_valid) begin
                $display("word_valid stayed high past %0d words in %s", FRAME_WORDS, what);
                other_errors++;
            end
            check_busy(busy, 1'b0, $sformatf("%s after last word", what));
        end
    endtask

    task automatic first_frame_after_reset();
        do_capture();
        collect_frame("reset frame");
    endtask

    task automatic single_pulse_counts();
        for (int i = 0; i < NUM_LINES; i++) begin
            repeat (i + 1) pulse_line(line_vec_t'(1 << i), 4); // Too far apart for any lag
        end
        repeat (3) pulse_line(4'b0010, 2);            // Two lag 2 hits on line 1
        do_capture();
        collect_frame("single pulses");
    endtask

    task automatic pair_and_random_counts();
        integer rnd;
        repeat (2) pulse_line(4'b0011, 4);
        pulse_line(4'b1100, 4);
        pulse_line(4'b0101, 4);
        pulse_line(4'b1111, 4);                       // Every pair at once
        do_capture();
        collect_frame("pair pulses");
        for (int n = 0; n < 200; n++) begin
            rnd = $random(seed);
            drive_lines(rnd[NUM_LINES-1:0]);
        end
        do_capture();
        collect_frame("random pattern");
    endtask

    task automatic capture_clears_counts();
        @(posedge clk);
        #1;
        apply_reset();
        repeat (5) pulse_line(4'b1001, 3);            // Lag 3 and pair (0,3) hits
        do_capture();
        collect_frame("first window");
        repeat (2) pulse_line(4'b0110, 4);
        do_capture();
        collect_frame("second window");               // Sequence 1, old counts gone
    endtask

    task automatic busy_capture_ignored();
        int quiet;
        repeat (3) pulse_line(4'b0100, 4);
        do_capture();
        @(posedge clk);
        #1;
        capture = 1'b1;                               // Lands while the frame starts
        @(posedge clk);
        #1;
        capture = 1'b0;
        collect_frame("capture while busy");
        quiet = 0;
        while (!word_valid && quiet < QUIET_LIMIT) begin
            @(negedge clk);
            quiet++;
        end
        if (word_valid) begin
            $display("An extra frame followed the capture sent while busy");
            other_errors++;
        end
    endtask

    task automatic lag0_saturation();
        for (int n = 0; n < 70000; n++) begin
            pulse_line(4'b0001, 2);                   // Lag 0 and lag 2 both overflow
        end
        do_capture();
        collect_frame("saturation");
    endtask

    initial begin
        value_errors = 0;
        other_errors = 0;
        seed         = 27;
        apply_reset();
        first_frame_after_reset();
        single_pulse_counts();
        pair_and_random_counts();
        capture_clears_counts();
        busy_capture_ignored();
        lag0_saturation();
        finish_run();
    end

endmodule

//--- xc_core.f
xc_cfg_pkg.sv
xc_types_pkg.sv
line_sampler.sv
auto_correlator.sv
cross_correlator.sv
report_framer.sv
xc_core.sv
tb_xc_core.sv

//--- run_sim.sh
#!/bin/sh
# Build the correlator core with its testbench under Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_xc_core \
    -f xc_core.f -o sim_xc_core \
    && ./obj_dir/sim_xc_core | tee sim.log \
    && grep -qx "TEST PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
